//--- source/cache_geom_pkg.sv
package cache_geom_pkg;

  localparam int num_ways  = 4;
  localparam int way_bits  = 2;
  localparam int set_bits  = 6;
  localparam int num_sets  = 64;
  localparam int tag_bits  = 10;
  localparam int addr_bits = 16; // tag above set
  localparam int word_bits = 32;
  localparam int num_bytes = 4;
  localparam int code_bits = 39;
  localparam int rank_bits = 2;

  // indexed by hamming position, check bits at the powers of two
  typedef logic [code_bits:1] code_t;
  typedef logic [num_ways-1:0][rank_bits-1:0] rank_vec_t;
  typedef logic [num_ways-1:0] way_vec_t;

  function automatic code_t ecc_encode(input logic [word_bits-1:0] data);
    code_t code;
    int    d;
    logic  par;
    code = '0;
    d = 0;
    for (int p = 3; p < code_bits; p++) begin
      if ((p & (p - 1)) != 0) begin
        code[p] = data[d];
        d++;
      end
    end
    for (int c = 0; (1 << c) < code_bits; c++) begin
      par = 1'b0;
      for (int p = 1; p < code_bits; p++) begin
        if (((p >> c) & 1) != 0) par ^= code[p];
      end
      code[1 << c] = par;
    end
    code[code_bits] = ^code[code_bits-1:1]; // overall parity on top
    return code;
  endfunction

  // no correction, data bits only
  function automatic logic [word_bits-1:0] ecc_strip(input code_t code);
    return {code[38:33], code[31:17], code[15:9], code[7:5], code[3]};
  endfunction

endpackage

//--- source/cache_txn_pkg.sv
package cache_txn_pkg;

  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1, // byte masked, hit only
    op_fill  = 2'd2
  } op_t;

  typedef struct packed {
    op_t                                   op;
    logic [cache_geom_pkg::addr_bits-1:0]  addr;
    logic [cache_geom_pkg::word_bits-1:0]  wdata;
    logic [cache_geom_pkg::num_bytes-1:0]  ben;
  } cache_req_t;

  typedef struct packed {
    logic                                  hit;
    logic [cache_geom_pkg::way_bits-1:0]   way;
    logic [cache_geom_pkg::word_bits-1:0]  rdata;
  } cache_resp_t;

endpackage

//--- source/ecc_word_merge.sv
`timescale 1ns/1ns

// read-modify-write combine for one way
module ecc_word_merge (
  input  cache_geom_pkg::code_t                 old_code,
  input  logic [cache_geom_pkg::word_bits-1:0]  new_word,
  input  logic [cache_geom_pkg::num_bytes-1:0]  ben,
  output cache_geom_pkg::code_t                 merged_code
);

  logic [cache_geom_pkg::word_bits-1:0] old_word;
  logic [cache_geom_pkg::word_bits-1:0] merged;

  assign old_word = cache_geom_pkg::ecc_strip(old_code);

  always_comb begin
    for (int b = 0; b < cache_geom_pkg::num_bytes; b++) begin
      if (ben[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end else begin
        merged[8*b +: 8] = old_word[8*b +: 8];
      end
    end
  end

  assign merged_code = cache_geom_pkg::ecc_encode(merged); // fresh check bits

endmodule

//--- source/data_bank.sv
`timescale 1ns/1ns

// one way's codeword storage
module data_bank (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [cache_geom_pkg::set_bits-1:0]  rd_set,
  output cache_geom_pkg::code_t                rd_code,
  input  logic                                 wr_en,
  input  logic [cache_geom_pkg::set_bits-1:0]  wr_set,
  input  cache_geom_pkg::code_t                wr_code
);

  cache_geom_pkg::code_t mem [cache_geom_pkg::num_sets];

  logic [cache_geom_pkg::set_bits-1:0] rd_set_q;

  // async read behind the address register, so a write shows up next cycle
  assign rd_code = mem[rd_set_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_set_q <= '0;
    end else begin
      rd_set_q <= rd_set;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_set] <= wr_code;
    end
  end

endmodule

//--- source/tag_way.sv
`timescale 1ns/1ns

module tag_way (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [cache_geom_pkg::set_bits-1:0]  rd_set,
  input  logic [cache_geom_pkg::tag_bits-1:0]  rd_tag,
  output logic                                 hit,
  input  logic                                 wr_en,
  input  logic [cache_geom_pkg::set_bits-1:0]  wr_set,
  input  logic [cache_geom_pkg::tag_bits-1:0]  wr_tag,
  input  logic                                 sweep_busy,
  input  logic [cache_geom_pkg::set_bits-1:0]  sweep_set
);

  typedef struct packed {
    logic                                valid;
    logic [cache_geom_pkg::tag_bits-1:0] tag;
  } tag_entry_t;

  tag_entry_t mem [cache_geom_pkg::num_sets];
  tag_entry_t entry;

  logic [cache_geom_pkg::set_bits-1:0] rd_set_q;
  logic [cache_geom_pkg::tag_bits-1:0] rd_tag_q; // compared with stored tag

  assign entry = mem[rd_set_q];
  assign hit   = entry.valid && (entry.tag == rd_tag_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_set_q <= '0;
      rd_tag_q <= '0;
    end else begin
      rd_set_q <= rd_set;
      rd_tag_q <= rd_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (sweep_busy) begin
      mem[sweep_set] <= '0; // invalidate during init
    end else if (wr_en) begin
      mem[wr_set] <= '{valid: 1'b1, tag: wr_tag};
    end
  end

endmodule

//--- source/lru_state.sv
`timescale 1ns/1ns

// per-set rank storage, rank 0 is most recent
module lru_state (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [cache_geom_pkg::set_bits-1:0]  rd_set,
  output logic [cache_geom_pkg::way_bits-1:0]  victim,
  input  logic                                 touch_en,
  input  logic [cache_geom_pkg::way_bits-1:0]  touch_way,
  output logic                                 sweep_busy,
  output logic [cache_geom_pkg::set_bits-1:0]  sweep_set
);

  cache_geom_pkg::rank_vec_t mem [cache_geom_pkg::num_sets];
  cache_geom_pkg::rank_vec_t ranks;
  cache_geom_pkg::rank_vec_t next_ranks;
  cache_geom_pkg::rank_vec_t init_ranks;

  logic [cache_geom_pkg::set_bits-1:0] rd_set_q;

  assign ranks = mem[rd_set_q];

  always_comb begin
    for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
      init_ranks[w] = cache_geom_pkg::rank_bits'(w); // way w starts at rank w
    end
  end

  always_comb begin
    victim = '0;
    for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
      if (ranks[w] == cache_geom_pkg::rank_bits'(cache_geom_pkg::num_ways - 1)) begin
        victim = cache_geom_pkg::way_bits'(w);
      end
    end
  end

  // touched way goes to 0, younger ones age by one
  always_comb begin
    next_ranks = ranks;
    for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
      if (w == int'(touch_way)) begin
        next_ranks[w] = '0;
      end else if (ranks[w] < ranks[touch_way]) begin
        next_ranks[w] = ranks[w] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_set_q   <= '0;
      sweep_busy <= 1'b1;
      sweep_set  <= '0;
    end else begin
      rd_set_q <= rd_set;
      if (sweep_busy) begin
        sweep_set <= sweep_set + 1'b1;
        if (sweep_set == cache_geom_pkg::set_bits'(cache_geom_pkg::num_sets - 1)) begin
          sweep_busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sweep_busy) begin
      mem[sweep_set] <= init_ranks;
    end else if (touch_en) begin
      mem[rd_set_q] <= next_ranks;
    end
  end

endmodule

//--- source/cache_store.sv
`timescale 1ns/1ns

module cache_store (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req,
  input  cache_txn_pkg::cache_req_t  req_data,
  output logic                       ack,
  output cache_txn_pkg::cache_resp_t resp
);

  typedef enum logic [1:0] {st_idle, st_lookup, st_compare, st_ack} state_t;

  state_t                               state;
  cache_txn_pkg::cache_req_t            req_q;
  logic [cache_geom_pkg::set_bits-1:0]  req_set;
  logic [cache_geom_pkg::tag_bits-1:0]  req_tag;
  logic [cache_geom_pkg::num_bytes-1:0] ben;
  cache_geom_pkg::way_vec_t             hit_vec;
  cache_geom_pkg::way_vec_t             data_wr;
  cache_geom_pkg::way_vec_t             tag_wr;
  cache_geom_pkg::code_t                old_code [cache_geom_pkg::num_ways];
  cache_geom_pkg::code_t                new_code [cache_geom_pkg::num_ways];
  logic [cache_geom_pkg::way_bits-1:0]  hit_way;
  logic [cache_geom_pkg::way_bits-1:0]  victim;
  logic [cache_geom_pkg::way_bits-1:0]  target;
  logic                                 hit_any;
  logic                                 is_fill;
  logic                                 compare;
  logic                                 sweep_busy;
  logic [cache_geom_pkg::set_bits-1:0]  sweep_set;

  assign req_set = req_q.addr[cache_geom_pkg::set_bits-1:0];
  assign req_tag = req_q.addr[cache_geom_pkg::set_bits +: cache_geom_pkg::tag_bits];
  assign is_fill = req_q.op == cache_txn_pkg::op_fill;
  assign ben     = is_fill ? '1 : req_q.ben; // fill writes the whole word
  assign compare = state == st_compare;
  assign hit_any = |hit_vec;
  assign target  = hit_any ? hit_way : victim;
  assign ack     = state == st_ack;

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
      if (hit_vec[w]) hit_way = cache_geom_pkg::way_bits'(w);
    end
  end

  always_comb begin
    data_wr = '0;
    tag_wr  = '0;
    if (compare && (is_fill || (hit_any && req_q.op == cache_txn_pkg::op_write))) begin
      data_wr[target] = 1'b1;
    end
    if (compare && is_fill) tag_wr[target] = 1'b1;
  end

  for (genvar g = 0; g < cache_geom_pkg::num_ways; g++) begin : g_way
    tag_way u_tag (
      .clk(clk), .rst(rst),
      .rd_set(req_set), .rd_tag(req_tag), .hit(hit_vec[g]),
      .wr_en(tag_wr[g]), .wr_set(req_set), .wr_tag(req_tag),
      .sweep_busy(sweep_busy), .sweep_set(sweep_set)
    );
    data_bank u_data (
      .clk(clk), .rst(rst),
      .rd_set(req_set), .rd_code(old_code[g]),
      .wr_en(data_wr[g]), .wr_set(req_set), .wr_code(new_code[g])
    );
    ecc_word_merge u_merge (
      .old_code(old_code[g]), .new_word(req_q.wdata), .ben(ben),
      .merged_code(new_code[g])
    );
  end

  lru_state u_lru (
    .clk(clk), .rst(rst), .rd_set(req_set), .victim(victim),
    .touch_en(compare && (hit_any || is_fill)), .touch_way(target),
    .sweep_busy(sweep_busy), .sweep_set(sweep_set)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:    if (req && !sweep_busy) state <= st_lookup; // held off by init
        st_lookup:  state <= st_compare;
        st_compare: state <= st_ack;
        st_ack:     if (!req) state <= st_idle;
        default:    state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && req && !sweep_busy) req_q <= req_data;
    if (compare) begin
      resp.hit   <= hit_any;
      resp.way   <= target;
      // pre-op word of the hitting way
      resp.rdata <= hit_any ? cache_geom_pkg::ecc_strip(old_code[hit_way]) : '0;
    end
  end

endmodule

//--- sim/cache_store_checker.sv
`timescale 1ns/1ns

module cache_store_checker (
  input logic                       clk,
  input logic                       rst,
  input logic                       req,
  input logic                       ack,
  input cache_txn_pkg::cache_resp_t resp
);

  int fail_count = 0;
  int wait_cycles;

  // req up, ack not yet
  always_ff @(posedge clk) begin
    if (rst || !req || ack) begin
      wait_cycles <= 0;
    end else begin
      wait_cycles <= wait_cycles + 1;
    end
  end

  ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
    else begin
      $error("ack rose while req was low");
      fail_count++;
    end

  ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
    else begin
      $error("ack dropped while req was still high");
      fail_count++;
    end

  resp_hold: assert property (@(posedge clk) disable iff (rst) ack |=> !ack || $stable(resp))
    else begin
      $error("resp changed while ack was high");
      fail_count++;
    end

  ack_wait: assert property (@(posedge clk) disable iff (rst) wait_cycles < 80) // sweep fits
    else begin
      $error("req waited too long for ack");
      fail_count++;
    end

endmodule

//--- sim/tb_cache_store.sv
`timescale 1ns/1ns

module tb_cache_store;

  logic                       clk;
  logic                       rst;
  logic                       req;
  cache_txn_pkg::cache_req_t  req_data;
  logic                       ack;
  cache_txn_pkg::cache_resp_t resp;

  // reference model per set and way
  logic [9:0]  m_tag   [cache_geom_pkg::num_sets][cache_geom_pkg::num_ways];
  logic        m_valid [cache_geom_pkg::num_sets][cache_geom_pkg::num_ways];
  logic [31:0] m_data  [cache_geom_pkg::num_sets][cache_geom_pkg::num_ways];
  logic [1:0]  m_rank  [cache_geom_pkg::num_sets][cache_geom_pkg::num_ways];

  int          errors;
  int          cycles;
  int          ack_cycle;
  int          seed;
  logic [31:0] rnd;

  cache_store dut (.clk(clk), .rst(rst), .req(req), .req_data(req_data), .ack(ack), .resp(resp));

  bind cache_store cache_store_checker u_checker (
    .clk(clk), .rst(rst), .req(req), .ack(ack), .resp(resp)
  );

  always #50 clk = ~clk;

  task automatic step();
    @(posedge clk);
    #5; // drive and sample away from the edge
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
    $display("error at %0t: %s expected %h got %h", $time, name, expected, got);
    errors++;
  endtask

  task automatic touch_rank(input int s, input int way);
    logic [1:0] old;
    old = m_rank[s][way];
    for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
      if (w == way) m_rank[s][w] = 2'd0;
      else if (m_rank[s][w] < old) m_rank[s][w] = m_rank[s][w] + 2'd1;
    end
  endtask

  task automatic do_transaction(input cache_txn_pkg::op_t op, input logic [15:0] addr,
                                input logic [31:0] wdata, input logic [3:0] ben);
    int          s;
    int          way;
    logic        hit;
    logic [31:0] exp_rdata;
    s = int'(addr[5:0]);
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
      if (m_rank[s][w] == 2'd3) way = w; // victim unless a way hits
    end
    for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == addr[15:6]) begin
        hit = 1'b1;
        way = w;
      end
    end
    exp_rdata = hit ? m_data[s][way] : 32'd0;
    if (op == cache_txn_pkg::op_fill) begin
      m_tag[s][way] = addr[15:6];
      m_valid[s][way] = 1'b1;
      m_data[s][way] = wdata;
    end else if (op == cache_txn_pkg::op_write && hit) begin
      for (int b = 0; b < 4; b++) begin
        if (ben[b]) m_data[s][way][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    if (hit || op == cache_txn_pkg::op_fill) touch_rank(s, way);
    req_data = '{op: op, addr: addr, wdata: wdata, ben: ben};
    req = 1'b1;
    do step(); while (!ack);
    ack_cycle = cycles;
    assert (resp.hit === hit) else show_mismatch("resp.hit", {31'd0, hit}, {31'd0, resp.hit});
    if (hit || op == cache_txn_pkg::op_fill) begin
      assert (resp.way === 2'(way)) else show_mismatch("resp.way", way, {30'd0, resp.way});
    end
    if (op == cache_txn_pkg::op_read || (op == cache_txn_pkg::op_write && !hit)) begin
      assert (resp.rdata === exp_rdata) else show_mismatch("resp.rdata", exp_rdata, resp.rdata);
    end
    repeat (2) step(); // req stays up with ack high
    req = 1'b0;
    do step(); while (ack);
    repeat (3) step(); // idle with req low
  endtask

  initial begin
    cycles = 0;
    while (cycles < 3000) begin // sweep plus ~60 transactions of up to 20 cycles
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, transactions did not complete", cycles);
    $display("Something failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    req = 1'b0;
    req_data = '0;
    errors = 0;
    ack_cycle = 0;
    seed = 3418;
    for (int s = 0; s < cache_geom_pkg::num_sets; s++) begin
      for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
        m_valid[s][w] = 1'b0;
        m_rank[s][w] = 2'(w);
      end
    end
    repeat (4) step();
    rst = 1'b0;
    assert (ack === 1'b0) else show_mismatch("ack", 32'd0, {31'd0, ack});
    do_transaction(cache_txn_pkg::op_read, 16'h1234, 32'd0, 4'h0); // raised during sweep
    assert (ack_cycle >= 4 + cache_geom_pkg::num_sets + 3) else begin
      $display("ack came at cycle %0d, before the reset sweep was done", ack_cycle);
      errors++;
    end
    do_transaction(cache_txn_pkg::op_fill, {10'h011, 6'd5}, $random(seed), 4'hf);
    do_transaction(cache_txn_pkg::op_read, {10'h011, 6'd5}, 32'd0, 4'h0);
    do_transaction(cache_txn_pkg::op_read, {10'h022, 6'd5}, 32'd0, 4'h0);
    do_transaction(cache_txn_pkg::op_write, {10'h011, 6'd5}, $random(seed), 4'b0101);
    do_transaction(cache_txn_pkg::op_read, {10'h011, 6'd5}, 32'd0, 4'h0);
    do_transaction(cache_txn_pkg::op_write, {10'h033, 6'd5}, $random(seed), 4'hf); // miss
    do_transaction(cache_txn_pkg::op_read, {10'h011, 6'd5}, 32'd0, 4'h0);
    do_transaction(cache_txn_pkg::op_read, {10'h033, 6'd5}, 32'd0, 4'h0);
    for (int i = 0; i < 4; i++) begin
      do_transaction(cache_txn_pkg::op_fill, {10'h100 + 10'(i), 6'd9}, $random(seed), 4'hf);
    end
    do_transaction(cache_txn_pkg::op_read, {10'h100, 6'd9}, 32'd0, 4'h0); // protect it
    do_transaction(cache_txn_pkg::op_fill, {10'h104, 6'd9}, $random(seed), 4'hf);
    do_transaction(cache_txn_pkg::op_fill, {10'h104, 6'd9}, $random(seed), 4'hf); // in place
    for (int i = 0; i < 5; i++) begin
      do_transaction(cache_txn_pkg::op_read, {10'h100 + 10'(i), 6'd9}, 32'd0, 4'h0);
    end
    repeat (30) begin
      rnd = $random(seed);
      do_transaction((rnd[1:0] == 2'd3) ? cache_txn_pkg::op_read : cache_txn_pkg::op_t'(rnd[1:0]),
                     {8'd0, rnd[3:2], 4'd0, rnd[5:4]}, $random(seed), rnd[9:6]);
    end
    repeat (2) step();
    $display("done with %0d value errors and %0d protocol errors", errors,
             dut.u_checker.fail_count);
    if (errors == 0 && dut.u_checker.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
source/cache_geom_pkg.sv
source/cache_txn_pkg.sv
source/ecc_word_merge.sv
source/data_bank.sv
source/tag_way.sv
source/lru_state.sv
source/cache_store.sv
sim/cache_store_checker.sv
sim/tb_cache_store.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cache_store
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJ_DIR)
